/* bench/tb_rd_xbar.sv */
// Read crossbar testbench
`include "xbar_cfg.svh"

// Single-entry memory on one master port
module mem_model #(
  parameter int unsigned PORT_IDX = 0
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  xbar_pkg::mst_ar_t ar_i,
  input  logic              ar_valid_i,
  output logic              ar_ready_o,
  output xbar_pkg::mst_r_t  r_o,
  output logic              r_valid_o,
  input  logic              r_ready_i,
  input  int unsigned       delay_i
);

  import xbar_pkg::*;

  logic        busy_q  = 1'b0;
  logic        valid_q = 1'b0;
  mst_r_t      beat_q  = '0;
  int unsigned wait_q  = 0;

  assign ar_ready_o = !busy_q;
  assign r_valid_o  = valid_q;
  assign r_o        = beat_q;

  always @(posedge clk_i) begin
    if (rst_i) begin
      busy_q  <= 1'b0;
      valid_q <= 1'b0;
      wait_q  <= 0;
    end else if (!busy_q) begin
      if (ar_valid_i) begin
        busy_q      <= 1'b1;
        wait_q      <= delay_i;
        // ID echoed, data tagged with the port index
        beat_q.id   <= ar_i.id;
        beat_q.data <= ar_i.addr ^ (data_t'(PORT_IDX) << 24);
        beat_q.resp <= RESP_OKAY;
      end
    end else if (valid_q) begin
      if (r_ready_i) begin
        busy_q  <= 1'b0;
        valid_q <= 1'b0;
      end
    end else if (wait_q <= 1) begin
      valid_q <= 1'b1;
    end else begin
      wait_q <= wait_q - 1;
    end
  end

endmodule

module tb_rd_xbar;

  import xbar_pkg::*;

  localparam int unsigned TIMEOUT = 50;

  logic clk = 1'b0;
  logic rst = 1'b1;
  int   seed = 32'h33d1fb31;

  slv_ar_t  [`XBAR_NUM_SLV-1:0]   slv_ar;
  logic     [`XBAR_NUM_SLV-1:0]   slv_ar_valid;
  logic     [`XBAR_NUM_SLV-1:0]   slv_ar_ready;
  slv_r_t   [`XBAR_NUM_SLV-1:0]   slv_r;
  logic     [`XBAR_NUM_SLV-1:0]   slv_r_valid;
  logic     [`XBAR_NUM_SLV-1:0]   slv_r_ready;
  mst_ar_t  [`XBAR_NUM_MST-1:0]   mst_ar;
  logic     [`XBAR_NUM_MST-1:0]   mst_ar_valid;
  logic     [`XBAR_NUM_MST-1:0]   mst_ar_ready;
  mst_r_t   [`XBAR_NUM_MST-1:0]   mst_r;
  logic     [`XBAR_NUM_MST-1:0]   mst_r_valid;
  logic     [`XBAR_NUM_MST-1:0]   mst_r_ready;
  rule_t    [`XBAR_NUM_RULES-1:0] addr_map;
  logic     [`XBAR_NUM_SLV-1:0]   en_default;
  mst_idx_t [`XBAR_NUM_SLV-1:0]   default_idx;

  // Memory latency per master port
  int unsigned mem_delay [`XBAR_NUM_MST];
  // Accepted ARs per master port and the last one seen
  int unsigned ar_cnt [`XBAR_NUM_MST];
  mst_ar_t     last_ar [`XBAR_NUM_MST];

  always #20 clk = ~clk;

  rd_xbar u_dut (
    .clk_i          (clk),
    .rst_i          (rst),
    .slv_ar_i       (slv_ar),
    .slv_ar_valid_i (slv_ar_valid),
    .slv_ar_ready_o (slv_ar_ready),
    .slv_r_o        (slv_r),
    .slv_r_valid_o  (slv_r_valid),
    .slv_r_ready_i  (slv_r_ready),
    .mst_ar_o       (mst_ar),
    .mst_ar_valid_o (mst_ar_valid),
    .mst_ar_ready_i (mst_ar_ready),
    .mst_r_i        (mst_r),
    .mst_r_valid_i  (mst_r_valid),
    .mst_r_ready_o  (mst_r_ready),
    .addr_map_i     (addr_map),
    .en_default_i   (en_default),
    .default_idx_i  (default_idx)
  );

  for (genvar j = 0; j < `XBAR_NUM_MST; j++) begin : gen_mem
    mem_model #(.PORT_IDX(j)) u_mem (
      .clk_i      (clk),
      .rst_i      (rst),
      .ar_i       (mst_ar[j]),
      .ar_valid_i (mst_ar_valid[j]),
      .ar_ready_o (mst_ar_ready[j]),
      .r_o        (mst_r[j]),
      .r_valid_o  (mst_r_valid[j]),
      .r_ready_i  (mst_r_ready[j]),
      .delay_i    (mem_delay[j])
    );
  end

  // AR monitor on the master ports
  always @(posedge clk) begin
    if (rst) begin
      for (int j = 0; j < `XBAR_NUM_MST; j++) begin
        ar_cnt[j]  <= 0;
        last_ar[j] <= '0;
      end
    end else begin
      for (int j = 0; j < `XBAR_NUM_MST; j++) begin
        if (mst_ar_valid[j] && mst_ar_ready[j]) begin
          ar_cnt[j]  <= ar_cnt[j] + 1;
          last_ar[j] <= mst_ar[j];
        end
      end
    end
  end

  task automatic fail_value(input string msg);
    $display("** Error at time %0t: %s", $time, msg);
    $display("tests failed");
    $fatal(1, "stopped on first error");
  endtask

  task automatic fail_timeout(input string what);
    $display("Timeout at time %0t while waiting for %s", $time, what);
    $display("tests failed");
    $fatal(1, "stopped on timeout");
  endtask

  // Expected memory data, address tagged with the port in the top byte
  function automatic data_t mem_data(input addr_t addr, input int unsigned port);
    return addr ^ {8'(port), 24'h0};
  endfunction

  task automatic send_ar(input int unsigned p, input slv_id_t id, input addr_t addr);
    int unsigned n;
    n = 0;
    @(posedge clk);
    slv_ar[p].id    <= id;
    slv_ar[p].addr  <= addr;
    slv_ar_valid[p] <= 1'b1;
    do begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) fail_timeout($sformatf("AR ready on slave port %0d", p));
    end while (!slv_ar_ready[p]);
    slv_ar_valid[p] <= 1'b0;
  endtask

  // R ready is always high, so a seen valid is also the handshake
  task automatic recv_r(input int unsigned p, input slv_id_t id, input data_t data,
                        input resp_t resp);
    int unsigned n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) fail_timeout($sformatf("R valid on slave port %0d", p));
    end while (!slv_r_valid[p]);
    assert (slv_r[p].id == id)
      else fail_value($sformatf("slave %0d R id %h, expected %h", p, slv_r[p].id, id));
    assert (slv_r[p].data == data)
      else fail_value($sformatf("slave %0d R data %h, expected %h", p, slv_r[p].data, data));
    assert (slv_r[p].resp == resp)
      else fail_value($sformatf("slave %0d R resp %0d, expected %0d", p, slv_r[p].resp, resp));
  endtask

  // One read that must reach the given master port
  task automatic read_check(input int unsigned s, input slv_id_t id, input addr_t addr,
                            input int unsigned port);
    int unsigned cnt_before;
    int unsigned other_before;
    mst_ar_t     exp_ar;
    cnt_before   = ar_cnt[port];
    other_before = ar_cnt[1 - port];
    exp_ar.id    = {1'(s), id};
    exp_ar.addr  = addr;
    fork
      send_ar(s, id, addr);
      recv_r(s, id, mem_data(addr, port), RESP_OKAY);
    join
    assert (ar_cnt[port] == cnt_before + 1)
      else fail_value($sformatf("addr %h did not reach master port %0d", addr, port));
    assert (ar_cnt[1 - port] == other_before)
      else fail_value($sformatf("addr %h reached master port %0d", addr, 1 - port));
    assert (last_ar[port] == exp_ar)
      else fail_value($sformatf("master %0d AR %h, expected %h", port, last_ar[port], exp_ar));
  endtask

  task automatic test_routing();
    addr_t a;
    for (int unsigned s = 0; s < `XBAR_NUM_SLV; s++) begin
      // Rule 0 below the overlap window
      a = $random(seed) & 32'h7FF;
      read_check(s, slv_id_t'(4'h1 + s), a, 0);
      a = 32'h1000 | ($random(seed) & 32'hFFF);
      read_check(s, slv_id_t'(4'h9 + s), a, 1);
    end
  endtask

  // Highest rule wins inside 0x800 to 0xC00
  task automatic test_overlap();
    addr_t a;
    a = 32'h800 | ($random(seed) & 32'h3FF);
    read_check(0, 4'h7, a, 1);
    read_check(1, 4'hC, a, 1);
  endtask

  task automatic test_decerr();
    int unsigned c0;
    int unsigned c1;
    c0 = ar_cnt[0];
    c1 = ar_cnt[1];
    fork
      send_ar(1, 4'hE, 32'h3000);
      recv_r(1, 4'hE, `XBAR_DECERR_DATA, RESP_DECERR);
    join
    assert ((ar_cnt[0] == c0) && (ar_cnt[1] == c1))
      else fail_value("unmapped read showed up on a master port");
  endtask

  task automatic test_default();
    @(posedge clk);
    en_default[1]  <= 1'b1;
    default_idx[1] <= 1'b1;
    read_check(1, 4'hE, 32'h3000, 1);
    @(posedge clk);
    en_default[1]  <= 1'b0;
  endtask

  // Both slave ports on master port 0 at once
  task automatic test_contention();
    int unsigned c0;
    addr_t       a0;
    addr_t       a1;
    c0 = ar_cnt[0];
    a0 = $random(seed) & 32'h7FF;
    a1 = $random(seed) & 32'h7FF;
    fork
      send_ar(0, 4'h5, a0);
      send_ar(1, 4'h6, a1);
      recv_r(0, 4'h5, mem_data(a0, 0), RESP_OKAY);
      recv_r(1, 4'h6, mem_data(a1, 0), RESP_OKAY);
    join
    assert (ar_cnt[0] == c0 + 2)
      else fail_value($sformatf("master port 0 took %0d reads, expected 2", ar_cnt[0] - c0));
  endtask

  // Slow port 0 first, then port 1 from the same slave port
  task automatic test_ordering();
    @(posedge clk);
    mem_delay[0] <= 8;
    fork
      begin
        send_ar(0, 4'h3, 32'h0100);
        send_ar(0, 4'h4, 32'h1100);
      end
      begin
        recv_r(0, 4'h3, mem_data(32'h0100, 0), RESP_OKAY);
        recv_r(0, 4'h4, mem_data(32'h1100, 1), RESP_OKAY);
      end
      begin
        int unsigned n;
        n = 0;
        do begin
          @(posedge clk);
          n++;
          assert (!mst_ar_valid[1])
            else fail_value("second AR reached master port 1 before the first R");
          if (n > TIMEOUT) fail_timeout("first R on slave port 0");
        end while (!slv_r_valid[0]);
      end
    join
    @(posedge clk);
    mem_delay[0] <= 1;
  endtask

  initial begin
    slv_ar       = '0;
    slv_ar_valid = '0;
    slv_r_ready  = '1;
    en_default   = '0;
    default_idx  = '0;
    mem_delay[0] = 1;
    mem_delay[1] = 2;
    // Rule 2 overlaps rule 0
    addr_map[0]  = '{idx: 1'b0, start_addr: 32'h0000, end_addr: 32'h1000};
    addr_map[1]  = '{idx: 1'b1, start_addr: 32'h1000, end_addr: 32'h2000};
    addr_map[2]  = '{idx: 1'b1, start_addr: 32'h0800, end_addr: 32'h0C00};
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    test_routing();
    test_overlap();
    test_decerr();
    test_default();
    test_contention();
    test_ordering();
    $display("all tests passed");
    $finish;
  end

endmodule

/* design/addr_decode.sv */
// Address map lookup
`include "xbar_cfg.svh"

module addr_decode (
  input  xbar_pkg::addr_t                       addr_i,
  input  xbar_pkg::rule_t [`XBAR_NUM_RULES-1:0] addr_map_i,
  input  logic                                  en_default_i,
  input  xbar_pkg::mst_idx_t                    default_idx_i,
  output xbar_pkg::mst_idx_t                    idx_o,
  output logic                                  dec_error_o
);

  import xbar_pkg::*;

  // Result of the rule scan
  logic     match;
  mst_idx_t match_idx;

  // Walk all rules in order
  // a later match overrides an earlier one, so the highest position wins
  always_comb begin
    match     = 1'b0;
    match_idx = '0;
    for (int unsigned r = 0; r < `XBAR_NUM_RULES; r++) begin
      if ((addr_i >= addr_map_i[r].start_addr) && (addr_i < addr_map_i[r].end_addr)) begin
        match     = 1'b1;
        match_idx = addr_map_i[r].idx;
      end
    end
  end

  // Fall back to the default port when enabled
  always_comb begin
    if (match) begin
      idx_o       = match_idx;
      dec_error_o = 1'b0;
    end else if (en_default_i) begin
      idx_o       = default_idx_i;
      dec_error_o = 1'b0;
    end else begin
      // Index is don't care on an error
      idx_o       = '0;
      dec_error_o = 1'b1;
    end
  end

endmodule

/* design/decerr_responder.sv */
// Decode-error read responder
`include "xbar_cfg.svh"

module decerr_responder (
  input  logic              clk_i,
  input  logic              rst_i,
  input  xbar_pkg::slv_ar_t ar_i,
  input  logic              ar_valid_i,
  output logic              ar_ready_o,
  output xbar_pkg::slv_r_t  r_o,
  output logic              r_valid_o,
  input  logic              r_ready_i
);

  import xbar_pkg::*;

  typedef enum logic {
    IDLE,
    RESP
  } state_e;

  state_e  state_q, state_d;
  // ID of the request being answered
  slv_id_t id_q;

  assign ar_ready_o = (state_q == IDLE);
  assign r_valid_o  = (state_q == RESP);

  // Fixed error beat, only the ID is echoed
  assign r_o.id   = id_q;
  assign r_o.data = data_t'(`XBAR_DECERR_DATA);
  assign r_o.resp = RESP_DECERR;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: if (ar_valid_i) state_d = RESP;
      RESP: if (r_ready_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture the ID on AR acceptance
  always_ff @(posedge clk_i) begin
    if (ar_valid_i && ar_ready_o) begin
      id_q <= ar_i.id;
    end
  end

endmodule

/* design/rd_demux.sv */
// Read demultiplexer for one slave port
`include "xbar_cfg.svh"

module rd_demux (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  // Slave port side
  input  xbar_pkg::slv_ar_t                     slv_ar_i,
  input  logic                                  slv_ar_valid_i,
  output logic                                  slv_ar_ready_o,
  output xbar_pkg::slv_r_t                      slv_r_o,
  output logic                                  slv_r_valid_o,
  input  logic                                  slv_r_ready_i,
  input  xbar_pkg::sel_t                        sel_i,
  // One leg per master port plus the error responder
  output xbar_pkg::slv_ar_t [`XBAR_NUM_MST:0]   mst_ar_o,
  output logic              [`XBAR_NUM_MST:0]   mst_ar_valid_o,
  input  logic              [`XBAR_NUM_MST:0]   mst_ar_ready_i,
  input  xbar_pkg::slv_r_t  [`XBAR_NUM_MST:0]   mst_r_i,
  input  logic              [`XBAR_NUM_MST:0]   mst_r_valid_i,
  output logic              [`XBAR_NUM_MST:0]   mst_r_ready_o
);

  import xbar_pkg::*;

  localparam int unsigned NUM_LEGS = `XBAR_NUM_MST + 1;
  localparam int unsigned CNT_W    = $clog2(`XBAR_MAX_TRANS + 1);

  // Outstanding reads and where they went
  logic [CNT_W-1:0] cnt_q;
  sel_t             dest_q;

  logic stall;
  logic leg_ready;
  logic ar_hs;
  logic r_hs;

  // Hold a new AR while reads to another leg are in flight, or when full
  assign stall = ((cnt_q != '0) && (dest_q != sel_i)) ||
                 (cnt_q == CNT_W'(`XBAR_MAX_TRANS));

  // AR payload goes to every leg, only the selected one sees valid
  always_comb begin
    leg_ready = 1'b0;
    for (int unsigned l = 0; l < NUM_LEGS; l++) begin
      mst_ar_o[l]       = slv_ar_i;
      mst_ar_valid_o[l] = slv_ar_valid_i && !stall && (sel_i == sel_t'(l));
      if (sel_i == sel_t'(l)) begin
        leg_ready = mst_ar_ready_i[l];
      end
    end
  end

  assign slv_ar_ready_o = !stall && leg_ready;
  assign ar_hs          = slv_ar_valid_i && slv_ar_ready_o;

  // R merge, lowest valid leg first
  // The ordering stall keeps at most one leg active anyway
  always_comb begin
    slv_r_o       = mst_r_i[0];
    slv_r_valid_o = 1'b0;
    mst_r_ready_o = '0;
    for (int unsigned l = 0; l < NUM_LEGS; l++) begin
      if (!slv_r_valid_o && mst_r_valid_i[l]) begin
        slv_r_o          = mst_r_i[l];
        slv_r_valid_o    = 1'b1;
        mst_r_ready_o[l] = slv_r_ready_i;
      end
    end
  end

  assign r_hs = slv_r_valid_o && slv_r_ready_i;

  // Outstanding counter and destination tracking
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q  <= '0;
      dest_q <= '0;
    end else begin
      if (ar_hs && !r_hs) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (r_hs && !ar_hs) begin
        cnt_q <= cnt_q - 1'b1;
      end
      // Destination only moves when nothing else is in flight
      if (ar_hs) begin
        dest_q <= sel_i;
      end
    end
  end

endmodule

/* design/rd_mux.sv */
// Read multiplexer for one master port
`include "xbar_cfg.svh"

module rd_mux (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  // One leg per slave port
  input  xbar_pkg::slv_ar_t [`XBAR_NUM_SLV-1:0] slv_ar_i,
  input  logic              [`XBAR_NUM_SLV-1:0] slv_ar_valid_i,
  output logic              [`XBAR_NUM_SLV-1:0] slv_ar_ready_o,
  output xbar_pkg::slv_r_t  [`XBAR_NUM_SLV-1:0] slv_r_o,
  output logic              [`XBAR_NUM_SLV-1:0] slv_r_valid_o,
  input  logic              [`XBAR_NUM_SLV-1:0] slv_r_ready_i,
  // Master port side
  output xbar_pkg::mst_ar_t                     mst_ar_o,
  output logic                                  mst_ar_valid_o,
  input  logic                                  mst_ar_ready_i,
  input  xbar_pkg::mst_r_t                      mst_r_i,
  input  logic                                  mst_r_valid_i,
  output logic                                  mst_r_ready_o
);

  import xbar_pkg::*;

  localparam int unsigned SLV_IDX_W = `XBAR_MST_ID_W - `XBAR_SLV_ID_W;

  typedef logic [SLV_IDX_W-1:0] slv_idx_t;

  // Round-robin pointer and the grant held under back-pressure
  slv_idx_t ptr_q;
  slv_idx_t gnt_q;
  logic     lock_q;

  slv_idx_t arb_idx;
  logic     arb_found;
  slv_idx_t win_idx;
  slv_idx_t r_idx;
  logic     ar_hs;

  // Search from the pointer for the first valid leg
  always_comb begin
    int unsigned cand;
    arb_idx   = ptr_q;
    arb_found = 1'b0;
    for (int unsigned k = 0; k < `XBAR_NUM_SLV; k++) begin
      cand = (int'(ptr_q) + k) % `XBAR_NUM_SLV;
      if (!arb_found && slv_ar_valid_i[cand]) begin
        arb_found = 1'b1;
        arb_idx   = slv_idx_t'(cand);
      end
    end
  end

  // A pending grant keeps its leg until the handshake
  assign win_idx        = lock_q ? gnt_q : arb_idx;
  assign mst_ar_valid_o = lock_q ? slv_ar_valid_i[gnt_q] : arb_found;

  // Winner's index goes on top of its ID
  assign mst_ar_o.id   = {win_idx, slv_ar_i[win_idx].id};
  assign mst_ar_o.addr = slv_ar_i[win_idx].addr;

  always_comb begin
    for (int unsigned s = 0; s < `XBAR_NUM_SLV; s++) begin
      slv_ar_ready_o[s] = mst_ar_ready_i && mst_ar_valid_o && (win_idx == slv_idx_t'(s));
    end
  end

  assign ar_hs = mst_ar_valid_o && mst_ar_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q  <= '0;
      gnt_q  <= '0;
      lock_q <= 1'b0;
    end else if (ar_hs) begin
      // Next search starts just past the winner
      ptr_q  <= slv_idx_t'((int'(win_idx) + 1) % `XBAR_NUM_SLV);
      lock_q <= 1'b0;
    end else if (mst_ar_valid_o) begin
      gnt_q  <= win_idx;
      lock_q <= 1'b1;
    end
  end

  // R goes back to the leg named by the ID prefix
  assign r_idx = mst_r_i.id[`XBAR_MST_ID_W-1 -: SLV_IDX_W];

  always_comb begin
    mst_r_ready_o = 1'b0;
    for (int unsigned s = 0; s < `XBAR_NUM_SLV; s++) begin
      // Prefix stripped on the way back
      slv_r_o[s].id     = mst_r_i.id[`XBAR_SLV_ID_W-1:0];
      slv_r_o[s].data   = mst_r_i.data;
      slv_r_o[s].resp   = mst_r_i.resp;
      slv_r_valid_o[s]  = mst_r_valid_i && (r_idx == slv_idx_t'(s));
      if (r_idx == slv_idx_t'(s)) begin
        mst_r_ready_o = slv_r_ready_i[s];
      end
    end
  end

endmodule

/* design/rd_xbar.sv */
// Read-only crossbar top
`include "xbar_cfg.svh"

module rd_xbar (
  input  logic                                    clk_i,
  input  logic                                    rst_i,
  // Slave ports, requesters connect here
  input  xbar_pkg::slv_ar_t  [`XBAR_NUM_SLV-1:0]  slv_ar_i,
  input  logic               [`XBAR_NUM_SLV-1:0]  slv_ar_valid_i,
  output logic               [`XBAR_NUM_SLV-1:0]  slv_ar_ready_o,
  output xbar_pkg::slv_r_t   [`XBAR_NUM_SLV-1:0]  slv_r_o,
  output logic               [`XBAR_NUM_SLV-1:0]  slv_r_valid_o,
  input  logic               [`XBAR_NUM_SLV-1:0]  slv_r_ready_i,
  // Master ports, memories connect here
  output xbar_pkg::mst_ar_t  [`XBAR_NUM_MST-1:0]  mst_ar_o,
  output logic               [`XBAR_NUM_MST-1:0]  mst_ar_valid_o,
  input  logic               [`XBAR_NUM_MST-1:0]  mst_ar_ready_i,
  input  xbar_pkg::mst_r_t   [`XBAR_NUM_MST-1:0]  mst_r_i,
  input  logic               [`XBAR_NUM_MST-1:0]  mst_r_valid_i,
  output logic               [`XBAR_NUM_MST-1:0]  mst_r_ready_o,
  // Address map and per slave port default
  input  xbar_pkg::rule_t    [`XBAR_NUM_RULES-1:0] addr_map_i,
  input  logic               [`XBAR_NUM_SLV-1:0]  en_default_i,
  input  xbar_pkg::mst_idx_t [`XBAR_NUM_SLV-1:0]  default_idx_i
);

  import xbar_pkg::*;

  // Demux legs, the last one of each goes to the error responder
  slv_ar_t [`XBAR_NUM_SLV-1:0][`XBAR_NUM_MST:0] dmx_ar;
  logic    [`XBAR_NUM_SLV-1:0][`XBAR_NUM_MST:0] dmx_ar_valid;
  logic    [`XBAR_NUM_SLV-1:0][`XBAR_NUM_MST:0] dmx_ar_ready;
  slv_r_t  [`XBAR_NUM_SLV-1:0][`XBAR_NUM_MST:0] dmx_r;
  logic    [`XBAR_NUM_SLV-1:0][`XBAR_NUM_MST:0] dmx_r_valid;
  logic    [`XBAR_NUM_SLV-1:0][`XBAR_NUM_MST:0] dmx_r_ready;

  // Mux legs, indexed master port first
  slv_ar_t [`XBAR_NUM_MST-1:0][`XBAR_NUM_SLV-1:0] mux_ar;
  logic    [`XBAR_NUM_MST-1:0][`XBAR_NUM_SLV-1:0] mux_ar_valid;
  logic    [`XBAR_NUM_MST-1:0][`XBAR_NUM_SLV-1:0] mux_ar_ready;
  slv_r_t  [`XBAR_NUM_MST-1:0][`XBAR_NUM_SLV-1:0] mux_r;
  logic    [`XBAR_NUM_MST-1:0][`XBAR_NUM_SLV-1:0] mux_r_valid;
  logic    [`XBAR_NUM_MST-1:0][`XBAR_NUM_SLV-1:0] mux_r_ready;

  for (genvar i = 0; i < `XBAR_NUM_SLV; i++) begin : gen_slv_port
    mst_idx_t dec_idx;
    logic     dec_error;
    sel_t     ar_sel;

    addr_decode u_decode (
      .addr_i        (slv_ar_i[i].addr),
      .addr_map_i    (addr_map_i),
      .en_default_i  (en_default_i[i]),
      .default_idx_i (default_idx_i[i]),
      .idx_o         (dec_idx),
      .dec_error_o   (dec_error)
    );

    // Unmapped reads go to the extra leg
    assign ar_sel = dec_error ? sel_t'(`XBAR_NUM_MST) : sel_t'(dec_idx);

    rd_demux u_demux (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .slv_ar_i       (slv_ar_i[i]),
      .slv_ar_valid_i (slv_ar_valid_i[i]),
      .slv_ar_ready_o (slv_ar_ready_o[i]),
      .slv_r_o        (slv_r_o[i]),
      .slv_r_valid_o  (slv_r_valid_o[i]),
      .slv_r_ready_i  (slv_r_ready_i[i]),
      .sel_i          (ar_sel),
      .mst_ar_o       (dmx_ar[i]),
      .mst_ar_valid_o (dmx_ar_valid[i]),
      .mst_ar_ready_i (dmx_ar_ready[i]),
      .mst_r_i        (dmx_r[i]),
      .mst_r_valid_i  (dmx_r_valid[i]),
      .mst_r_ready_o  (dmx_r_ready[i])
    );

    decerr_responder u_decerr (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .ar_i       (dmx_ar[i][`XBAR_NUM_MST]),
      .ar_valid_i (dmx_ar_valid[i][`XBAR_NUM_MST]),
      .ar_ready_o (dmx_ar_ready[i][`XBAR_NUM_MST]),
      .r_o        (dmx_r[i][`XBAR_NUM_MST]),
      .r_valid_o  (dmx_r_valid[i][`XBAR_NUM_MST]),
      .r_ready_i  (dmx_r_ready[i][`XBAR_NUM_MST])
    );

    // Cross the remaining legs over to the muxes
    for (genvar j = 0; j < `XBAR_NUM_MST; j++) begin : gen_cross
      assign mux_ar[j][i]       = dmx_ar[i][j];
      assign mux_ar_valid[j][i] = dmx_ar_valid[i][j];
      assign dmx_ar_ready[i][j] = mux_ar_ready[j][i];
      assign dmx_r[i][j]        = mux_r[j][i];
      assign dmx_r_valid[i][j]  = mux_r_valid[j][i];
      assign mux_r_ready[j][i]  = dmx_r_ready[i][j];
    end
  end

  for (genvar j = 0; j < `XBAR_NUM_MST; j++) begin : gen_mst_port
    rd_mux u_mux (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .slv_ar_i       (mux_ar[j]),
      .slv_ar_valid_i (mux_ar_valid[j]),
      .slv_ar_ready_o (mux_ar_ready[j]),
      .slv_r_o        (mux_r[j]),
      .slv_r_valid_o  (mux_r_valid[j]),
      .slv_r_ready_i  (mux_r_ready[j]),
      .mst_ar_o       (mst_ar_o[j]),
      .mst_ar_valid_o (mst_ar_valid_o[j]),
      .mst_ar_ready_i (mst_ar_ready_i[j]),
      .mst_r_i        (mst_r_i[j]),
      .mst_r_valid_i  (mst_r_valid_i[j]),
      .mst_r_ready_o  (mst_r_ready_o[j])
    );
  end

endmodule

/* design/xbar_pkg.sv */
// Read crossbar types
`include "xbar_cfg.svh"

package xbar_pkg;

  // Vectors with a meaning of their own
  typedef logic [`XBAR_ADDR_W-1:0]   addr_t;
  typedef logic [`XBAR_DATA_W-1:0]   data_t;
  typedef logic [`XBAR_SLV_ID_W-1:0] slv_id_t;
  // Top bit carries the slave port index
  typedef logic [`XBAR_MST_ID_W-1:0] mst_id_t;
  typedef logic [$clog2(`XBAR_NUM_MST)-1:0] mst_idx_t;
  // One extra value selects the decode-error responder
  typedef logic [$clog2(`XBAR_NUM_MST + 1)-1:0] sel_t;
  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_DECERR = 2'b11;

  // Address rule, start included and end excluded
  typedef struct packed {
    mst_idx_t idx;
    addr_t    start_addr;
    addr_t    end_addr;
  } rule_t;

  // AR channel payloads
  typedef struct packed {
    slv_id_t id;
    addr_t   addr;
  } slv_ar_t;

  typedef struct packed {
    mst_id_t id;
    addr_t   addr;
  } mst_ar_t;

  // R channel payloads
  typedef struct packed {
    slv_id_t id;
    data_t   data;
    resp_t   resp;
  } slv_r_t;

  typedef struct packed {
    mst_id_t id;
    data_t   data;
    resp_t   resp;
  } mst_r_t;

endpackage

/* include/xbar_cfg.svh */
// Read crossbar configuration
`ifndef XBAR_CFG_SVH
`define XBAR_CFG_SVH

// Port counts on both sides of the crossbar
`define XBAR_NUM_SLV 2
`define XBAR_NUM_MST 2
`define XBAR_NUM_RULES 3

// Channel widths
`define XBAR_ADDR_W 32
`define XBAR_DATA_W 32
`define XBAR_SLV_ID_W 4
// Slave ID grows by the bits of the slave port index
`define XBAR_MST_ID_W (`XBAR_SLV_ID_W + $clog2(`XBAR_NUM_SLV))

// Outstanding reads per slave port
`define XBAR_MAX_TRANS 4
// Read data returned with a decode error
`define XBAR_DECERR_DATA 32'hBADCAB1E

`endif

/* run.sh */
#!/bin/sh
# Build the read crossbar testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f --top-module tb_rd_xbar -o tb_rd_xbar
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_rd_xbar)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
  exit 0
fi
echo "Pass line not found in simulation output"
exit 1

/* sources.f */
+incdir+include
design/xbar_pkg.sv
design/addr_decode.sv
design/rd_demux.sv
design/decerr_responder.sv
design/rd_mux.sv
design/rd_xbar.sv
bench/tb_rd_xbar.sv
